// File: flist.f
+incdir+include
logic/hsi_pkg.sv
logic/hsi_frame_tx.sv
logic/hsi_line_rx.sv
logic/hsi_frame_merge.sv
logic/hsi_link.sv
verif/hsi_link_chk.sv
verif/hsi_link_tb.sv

// File: include/hsi_macros.svh
`ifndef HSI_MACROS_SVH
`define HSI_MACROS_SVH

// Bit timing, shared by transmitter and receivers
`define HSI_BIT_CYCLES 4
`define HSI_HALF_BIT (`HSI_BIT_CYCLES / 2)
`define HSI_BIT_CNT_W 2

// Start, 8 data, parity, stop
`define HSI_FRAME_BITS 11
`define HSI_IDX_W 4
`define HSI_DATA_BITS 8
`define HSI_DATA_IDX_W 3

// Cycles the merger waits for the late receiver
`define HSI_MERGE_WINDOW 8
`define HSI_WIN_CNT_W 4

`endif

// File: logic/hsi_frame_merge.sv
`timescale 1ns/1ps
`include "hsi_macros.svh"

module hsi_frame_merge (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       done1,
	input  logic       ok1,
	input  logic [7:0] q1,
	input  logic       done2,
	input  logic       ok2,
	input  logic [7:0] q2,
	output logic [7:0] rx_q,
	output logic       rx_valid,
	output logic       rx_err,
	output logic       rx_degraded
);

	hsi_pkg::merge_state_t state;

	logic [`HSI_WIN_CNT_W-1:0] cnt;
	logic                      first_is1;
	logic                      f_ok;
	logic [7:0]                f_q;
	logic                      open_win;
	logic                      other_done;
	logic                      win_end;
	logic                      close;
	logic                      r1_ok;
	logic                      r2_ok;
	logic [7:0]                r1_q;
	logic [7:0]                r2_q;
	logic                      any_ok;
	logic                      degraded;

	// Only one side done, start waiting for the other
	assign open_win   = (state == hsi_pkg::MG_IDLE) && (done1 ^ done2);
	assign other_done = first_is1 ? done2 : done1;
	assign win_end    = (cnt == `HSI_WIN_CNT_W'(`HSI_MERGE_WINDOW - 1));

	// Per-line view of the results; a missing side counts as not ok
	always_comb begin
		if (state == hsi_pkg::MG_WAIT) begin
			r1_ok = first_is1 ? f_ok : (ok1 & done1);
			r1_q  = first_is1 ? f_q : q1;
			r2_ok = first_is1 ? (ok2 & done2) : f_ok;
			r2_q  = first_is1 ? q2 : f_q;
			close = other_done | win_end;
		end else begin
			r1_ok = ok1 & done1;
			r1_q  = q1;
			r2_ok = ok2 & done2;
			r2_q  = q2;
			close = done1 & done2;
		end
	end

	assign any_ok   = r1_ok | r2_ok;
	assign degraded = ~(r1_ok & r2_ok) | (r1_q != r2_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= hsi_pkg::MG_IDLE;
			cnt         <= '0;
			first_is1   <= 1'b0;
			rx_valid    <= 1'b0;
			rx_err      <= 1'b0;
			rx_degraded <= 1'b0;
		end else begin
			rx_valid    <= close & any_ok;
			rx_err      <= close & ~any_ok;
			rx_degraded <= close & any_ok & degraded;
			case (state)
				hsi_pkg::MG_IDLE: begin
					if (open_win) begin
						state     <= hsi_pkg::MG_WAIT;
						cnt       <= '0;
						first_is1 <= done1;
					end
				end
				hsi_pkg::MG_WAIT: begin
					if (close) begin
						state <= hsi_pkg::MG_IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (open_win) begin
			f_ok <= done1 ? ok1 : ok2;
			f_q  <= done1 ? q1 : q2;
		end
		// Line 1 wins when both are ok
		if (close) begin
			rx_q <= r1_ok ? r1_q : r2_q;
		end
	end

endmodule

// File: logic/hsi_frame_tx.sv
`timescale 1ns/1ps
`include "hsi_macros.svh"

module hsi_frame_tx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_d,
	output logic       com1,
	output logic       com2,
	output logic       tx_busy
);

	hsi_pkg::tx_state_t state;

	logic [`HSI_FRAME_BITS-1:0] frame;
	logic [`HSI_BIT_CNT_W-1:0]  bit_cnt;
	logic [`HSI_IDX_W-1:0]      bit_idx;
	logic                       accept;
	logic                       last_cycle;
	logic                       last_bit;
	logic                       line_bit;

	// Strobes during a frame are dropped
	assign accept = (state == hsi_pkg::TX_IDLE) && tx_start;

	assign last_cycle = (bit_cnt == `HSI_BIT_CNT_W'(`HSI_BIT_CYCLES - 1));
	assign last_bit   = (bit_idx == `HSI_IDX_W'(`HSI_FRAME_BITS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= hsi_pkg::TX_IDLE;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				hsi_pkg::TX_IDLE: begin
					if (accept) begin
						state   <= hsi_pkg::TX_SEND;
						bit_cnt <= '0;
						bit_idx <= '0;
					end
				end
				hsi_pkg::TX_SEND: begin
					if (last_cycle) begin
						bit_cnt <= '0;
						if (last_bit) begin
							state <= hsi_pkg::TX_IDLE;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// Frame image, LSB goes out first
	// stop, odd parity, data, start
	always_ff @(posedge clk) begin
		if (accept) begin
			frame <= {1'b1, ~^tx_d, tx_d, 1'b0};
		end else if (state == hsi_pkg::TX_SEND && last_cycle) begin
			frame <= {1'b1, frame[`HSI_FRAME_BITS-1:1]};
		end
	end

	assign tx_busy = (state == hsi_pkg::TX_SEND);

	// Line idles high between frames
	assign line_bit = tx_busy ? frame[0] : 1'b1;

	// Both lines carry the same frame
	assign com1 = line_bit;
	assign com2 = line_bit;

endmodule

// File: logic/hsi_line_rx.sv
`timescale 1ns/1ps
`include "hsi_macros.svh"

module hsi_line_rx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       line,
	output logic [7:0] q,
	output logic       done,
	output logic       ok
);

	hsi_pkg::rx_state_t state;

	logic                          line_s1;
	logic                          line_s2;
	logic                          line_d;
	logic                          fall;
	logic [`HSI_BIT_CNT_W-1:0]     cnt;
	logic [`HSI_DATA_IDX_W-1:0]    data_idx;
	logic                          mid_start;
	logic                          mid_bit;
	logic                          last_data;
	logic [7:0]                    shreg;
	logic                          parity;

	// Two-flop synchronizer plus one stage for edge detection
	// Held high in reset so no false start edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			line_s1 <= 1'b1;
			line_s2 <= 1'b1;
			line_d  <= 1'b1;
		end else begin
			line_s1 <= line;
			line_s2 <= line_s1;
			line_d  <= line_s2;
		end
	end

	assign fall = line_d & ~line_s2;

	// Half a bit after the edge, then a full bit between samples
	assign mid_start = (cnt == `HSI_BIT_CNT_W'(`HSI_HALF_BIT - 1));
	assign mid_bit   = (cnt == `HSI_BIT_CNT_W'(`HSI_BIT_CYCLES - 1));
	assign last_data = (data_idx == `HSI_DATA_IDX_W'(`HSI_DATA_BITS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= hsi_pkg::RX_IDLE;
			cnt      <= '0;
			data_idx <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				hsi_pkg::RX_IDLE: begin
					if (fall) begin
						state <= hsi_pkg::RX_START;
						cnt   <= '0;
					end
				end
				hsi_pkg::RX_START: begin
					if (mid_start) begin
						cnt      <= '0;
						data_idx <= '0;
						// Glitch, not a start bit
						state    <= line_s2 ? hsi_pkg::RX_IDLE : hsi_pkg::RX_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				hsi_pkg::RX_DATA: begin
					cnt <= cnt + 1'b1;
					if (mid_bit) begin
						data_idx <= data_idx + 1'b1;
						if (last_data) begin
							state <= hsi_pkg::RX_PARITY;
						end
					end
				end
				hsi_pkg::RX_PARITY: begin
					cnt <= cnt + 1'b1;
					if (mid_bit) begin
						state <= hsi_pkg::RX_STOP;
					end
				end
				hsi_pkg::RX_STOP: begin
					cnt <= cnt + 1'b1;
					if (mid_bit) begin
						state <= hsi_pkg::RX_IDLE;
						done  <= 1'b1;
					end
				end
				default: state <= hsi_pkg::RX_IDLE;
			endcase
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge clk) begin
		case (state)
			hsi_pkg::RX_START: parity <= 1'b0;
			hsi_pkg::RX_DATA: begin
				if (mid_bit) begin
					shreg  <= {line_s2, shreg[7:1]};
					parity <= parity ^ line_s2;
				end
			end
			hsi_pkg::RX_PARITY: begin
				if (mid_bit) begin
					parity <= parity ^ line_s2;
				end
			end
			hsi_pkg::RX_STOP: begin
				if (mid_bit) begin
					q  <= shreg;
					// Odd count of ones over data and parity, stop bit high
					ok <= parity & line_s2;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// File: logic/hsi_link.sv
`timescale 1ns/1ps

module hsi_link (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_d,
	input  logic       line1,
	input  logic       line2,
	output logic       com1,
	output logic       com2,
	output logic       tx_busy,
	output logic [7:0] rx_q,
	output logic       rx_valid,
	output logic       rx_err,
	output logic       rx_degraded
);

	logic [7:0] q1;
	logic [7:0] q2;
	logic       done1;
	logic       done2;
	logic       ok1;
	logic       ok2;

	hsi_frame_tx tx (
		.clk(clk),
		.rst_n(rst_n),
		.tx_start(tx_start),
		.tx_d(tx_d),
		.com1(com1),
		.com2(com2),
		.tx_busy(tx_busy)
	);

	// Receivers run side by side, one per line
	hsi_line_rx rx1 (
		.clk(clk),
		.rst_n(rst_n),
		.line(line1),
		.q(q1),
		.done(done1),
		.ok(ok1)
	);

	hsi_line_rx rx2 (
		.clk(clk),
		.rst_n(rst_n),
		.line(line2),
		.q(q2),
		.done(done2),
		.ok(ok2)
	);

	hsi_frame_merge merge (
		.clk(clk),
		.rst_n(rst_n),
		.done1(done1),
		.ok1(ok1),
		.q1(q1),
		.done2(done2),
		.ok2(ok2),
		.q2(q2),
		.rx_q(rx_q),
		.rx_valid(rx_valid),
		.rx_err(rx_err),
		.rx_degraded(rx_degraded)
	);

endmodule

// File: logic/hsi_pkg.sv
package hsi_pkg;

	// Transmitter
	typedef enum logic [0:0] {
		TX_IDLE = 1'b0,
		TX_SEND = 1'b1
	} tx_state_t;

	// Line receiver, one state per frame field
	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0,
		RX_START  = 3'd1,
		RX_DATA   = 3'd2,
		RX_PARITY = 3'd3,
		RX_STOP   = 3'd4
	} rx_state_t;

	// Merger
	// MG_WAIT holds the first result while the window is open
	typedef enum logic [0:0] {
		MG_IDLE = 1'b0,
		MG_WAIT = 1'b1
	} merge_state_t;

endpackage

// File: run.sh
#!/bin/sh
# Build and run the hsi_link testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f flist.f --top-module hsi_link_tb -o hsi_link_sim &&
./obj_dir/hsi_link_sim || exit 1

// File: verif/hsi_link_chk.sv
`timescale 1ns/1ps

module hsi_link_chk (
	input logic clk,
	input logic rst_n,
	input logic com1,
	input logic com2,
	input logic tx_busy,
	input logic rx_valid,
	input logic rx_err,
	input logic rx_degraded
);

	// Both lines carry the same frame
	a_com_equal: assert property (@(posedge clk) disable iff (!rst_n)
		com1 == com2)
		else $error("com1 and com2 differ");

	// One verdict per merged frame
	a_valid_err: assert property (@(posedge clk) disable iff (!rst_n)
		!(rx_valid && rx_err))
		else $error("rx_valid and rx_err high together");

	// Line idles high outside a frame
	a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
		!tx_busy |-> com1)
		else $error("com1 low while transmitter idle");

	a_degraded: assert property (@(posedge clk) disable iff (!rst_n)
		rx_degraded |-> rx_valid)
		else $error("rx_degraded high without rx_valid");

endmodule

// File: verif/hsi_link_tb.sv
`timescale 1ns/1ps
`include "hsi_macros.svh"

module hsi_link_tb;

	localparam int BIT = `HSI_BIT_CYCLES;
	localparam int FRAME_CYCLES = `HSI_FRAME_BITS * `HSI_BIT_CYCLES;
	localparam int RESULT_TIMEOUT = 2 * FRAME_CYCLES + `HSI_MERGE_WINDOW;
	// 20 clean, 8 skewed, 6 one bad, 4 both bad, 1 tx format, 4 loopback
	localparam int TOTAL_FRAMES = 43;
	localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * 80 + 1000;

	localparam logic [1:0] MODE_CLEAN  = 2'd0;
	localparam logic [1:0] MODE_PARITY = 2'd1;
	localparam logic [1:0] MODE_NOSTOP = 2'd2;
	localparam logic [1:0] MODE_IDLE   = 2'd3;

	logic       clk;
	logic       rst_n;
	logic       tx_start;
	logic [7:0] tx_d;
	logic       line1;
	logic       line2;
	logic       com1;
	logic       com2;
	logic       tx_busy;
	logic [7:0] rx_q;
	logic       rx_valid;
	logic       rx_err;
	logic       rx_degraded;
	logic       loopback;
	logic [31:0] seed;

	hsi_link hsi_link_inst (
		.clk(clk),
		.rst_n(rst_n),
		.tx_start(tx_start),
		.tx_d(tx_d),
		.line1(line1),
		.line2(line2),
		.com1(com1),
		.com2(com2),
		.tx_busy(tx_busy),
		.rx_q(rx_q),
		.rx_valid(rx_valid),
		.rx_err(rx_err),
		.rx_degraded(rx_degraded)
	);

	bind hsi_link hsi_link_chk chk_inst (
		.clk(clk),
		.rst_n(rst_n),
		.com1(com1),
		.com2(com2),
		.tx_busy(tx_busy),
		.rx_valid(rx_valid),
		.rx_err(rx_err),
		.rx_degraded(rx_degraded)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Transmitter output looped back onto the receive lines
	always @(posedge clk) begin
		#1;
		if (loopback) begin
			line1 = com1;
			line2 = com2;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("simulation hung, watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$fatal(1);
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Start bit, data LSB first, odd parity, stop bit
	function automatic logic [10:0] build_frame(input logic [7:0] b, input logic [1:0] mode);
		logic [10:0] f;
		f[0] = 1'b0;
		f[8:1] = b;
		// Parity bit makes the count of ones odd
		f[9] = ($countones(b) % 2 == 0);
		f[10] = 1'b1;
		if (mode == MODE_PARITY) begin
			f[9] = ~f[9];
		end else if (mode == MODE_NOSTOP) begin
			f[10] = 1'b0;
		end else if (mode == MODE_IDLE) begin
			f = '1;
		end
		return f;
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("error %s expected 0x%0h got 0x%0h", name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Line 2 lags line 1 by skew cycles
	task automatic drive_frame(input logic [7:0] b1, input logic [1:0] m1,
			input logic [7:0] b2, input logic [1:0] m2, input int skew);
		logic [10:0] f1;
		logic [10:0] f2;
		int c;
		f1 = build_frame(b1, m1);
		f2 = build_frame(b2, m2);
		for (c = 0; c < FRAME_CYCLES + skew; c++) begin
			line1 = (c < FRAME_CYCLES) ? f1[c / BIT] : 1'b1;
			line2 = (c >= skew && c - skew < FRAME_CYCLES) ? f2[(c - skew) / BIT] : 1'b1;
			@(posedge clk);
			#1;
		end
		line1 = 1'b1;
		line2 = 1'b1;
	endtask

	task automatic wait_result(output logic v, output logic e, output logic d,
			output logic [7:0] q);
		int n;
		n = 0;
		while (!(rx_valid || rx_err) && n < RESULT_TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (rx_valid || rx_err) else begin
			$display("no rx_valid or rx_err within %0d cycles", RESULT_TIMEOUT);
			$display("Test failed");
			$fatal(1);
		end
		v = rx_valid;
		e = rx_err;
		d = rx_degraded;
		q = rx_q;
	endtask

	// Expected verdict follows the merge rules, line 1 wins a tie
	task automatic check_link(input logic [7:0] b1, input logic [1:0] m1,
			input logic [7:0] b2, input logic [1:0] m2, input int skew);
		logic ok1;
		logic ok2;
		logic exp_valid;
		logic exp_deg;
		logic [7:0] exp_q;
		logic v;
		logic e;
		logic d;
		logic [7:0] q;
		ok1 = (m1 == MODE_CLEAN);
		ok2 = (m2 == MODE_CLEAN);
		exp_valid = ok1 | ok2;
		exp_q = ok1 ? b1 : b2;
		exp_deg = exp_valid && (!(ok1 && ok2) || b1 != b2);
		drive_frame(b1, m1, b2, m2, skew);
		wait_result(v, e, d, q);
		check_value("rx_valid", 16'(exp_valid), 16'(v));
		check_value("rx_err", 16'(!exp_valid), 16'(e));
		check_value("rx_degraded", 16'(exp_deg), 16'(d));
		if (exp_valid) begin
			check_value("rx_q", 16'(exp_q), 16'(q));
		end
		idle_cycles(3);
	endtask

	task automatic clean_frames();
		repeat (20) begin
			seed = lcg_step(seed);
			check_link(seed[23:16], MODE_CLEAN, seed[23:16], MODE_CLEAN, 0);
		end
	endtask

	task automatic skewed_frames();
		repeat (8) begin
			seed = lcg_step(seed);
			check_link(seed[23:16], MODE_CLEAN, seed[23:16], MODE_CLEAN, int'(seed[9:8]));
		end
	endtask

	// Bad line carries another byte so rx_q shows which side was taken
	task automatic one_bad_line();
		logic [7:0] b;
		seed = lcg_step(seed);
		b = seed[23:16];
		check_link(~b, MODE_PARITY, b, MODE_CLEAN, 0);
		check_link(b, MODE_CLEAN, ~b, MODE_PARITY, 1);
		check_link(~b, MODE_NOSTOP, b, MODE_CLEAN, 2);
		check_link(b, MODE_CLEAN, ~b, MODE_NOSTOP, 0);
		check_link(b, MODE_IDLE, ~b, MODE_CLEAN, 0);
		check_link(b, MODE_CLEAN, ~b, MODE_IDLE, 0);
	endtask

	task automatic both_bad_lines();
		logic [7:0] b;
		seed = lcg_step(seed);
		b = seed[23:16];
		check_link(b, MODE_PARITY, b, MODE_NOSTOP, 0);
		check_link(b, MODE_PARITY, b, MODE_PARITY, 2);
		check_link(b, MODE_CLEAN, b ^ 8'h5a, MODE_CLEAN, 0);
		check_link(~b, MODE_CLEAN, b, MODE_CLEAN, 3);
	endtask

	// Busy length, bit order at mid-bit, strobe ignored while busy
	task automatic tx_frame_format();
		logic [7:0] d;
		logic [10:0] exp_frame;
		logic [10:0] got_frame;
		int i;
		seed = lcg_step(seed);
		d = seed[23:16];
		exp_frame = build_frame(d, MODE_CLEAN);
		got_frame = '1;
		i = 0;
		tx_d = d;
		tx_start = 1'b1;
		@(posedge clk);
		#1;
		tx_start = 1'b0;
		while (tx_busy && i < 2 * FRAME_CYCLES) begin
			if (i < FRAME_CYCLES && i % BIT == BIT / 2) begin
				got_frame[i / BIT] = com1;
			end
			if (i == 20) begin
				tx_d = ~d;
				tx_start = 1'b1;
			end else if (i == 21) begin
				tx_start = 1'b0;
			end
			@(posedge clk);
			#1;
			i++;
		end
		check_value("tx_busy cycles", 16'(FRAME_CYCLES), 16'(i));
		check_value("com1 frame", 16'(exp_frame), 16'(got_frame));
		repeat (3 * BIT) begin
			check_value("tx_busy", 16'h0, 16'(tx_busy));
			check_value("com1", 16'h1, 16'(com1));
			@(posedge clk);
			#1;
		end
	endtask

	task automatic loopback_frames();
		logic v;
		logic e;
		logic d;
		logic [7:0] q;
		loopback = 1'b1;
		repeat (4) begin
			seed = lcg_step(seed);
			tx_d = seed[23:16];
			tx_start = 1'b1;
			@(posedge clk);
			#1;
			tx_start = 1'b0;
			wait_result(v, e, d, q);
			check_value("rx_valid", 16'h1, 16'(v));
			check_value("rx_degraded", 16'h0, 16'(d));
			check_value("rx_q", 16'(tx_d), 16'(q));
			idle_cycles(3);
		end
		loopback = 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		tx_start = 1'b0;
		tx_d = 8'h00;
		line1 = 1'b1;
		line2 = 1'b1;
		loopback = 1'b0;
		seed = 32'ha4dc08ab;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value("tx_busy", 16'h0, 16'(tx_busy));
		check_value("rx_valid", 16'h0, 16'(rx_valid));
		check_value("rx_err", 16'h0, 16'(rx_err));
		check_value("rx_degraded", 16'h0, 16'(rx_degraded));
		check_value("com1", 16'h1, 16'(com1));
		idle_cycles(2);
		clean_frames();
		skewed_frames();
		one_bad_line();
		both_bad_lines();
		tx_frame_format();
		loopback_frames();
		$display("Test passed");
		$finish;
	end

endmodule
